// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/rob_core.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_core #(
    parameter int depth = `ROB_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            alloc_we,
    input  rob_pkg::entry_t alloc,
    output rob_pkg::tag_t   alloc_tag,
    output logic            full,
    input  rob_pkg::wb_t    alu_wb,
    input  rob_pkg::wb_t    addr_wb,
    input  rob_pkg::wb_t    mem_wb,
    output rob_pkg::entry_t head,
    output rob_pkg::tag_t   head_tag,
    output logic            head_valid,
    input  logic            advance,
    input  logic            released
);
    import rob_pkg::*;

    localparam logic [`ROB_TAG_W:0] max_count = depth[`ROB_TAG_W:0];

    entry_t                ents [depth];
    tag_t                  head_ptr;
    tag_t                  tail_ptr;
    logic [`ROB_TAG_W:0]   count;
    logic [`ROB_TAG_W:0]   count_next;

    function automatic tag_t next_ptr(tag_t ptr);
        return (ptr == tag_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign alloc_tag  = tail_ptr;
    assign head_tag   = head_ptr;
    assign head       = ents[head_ptr];
    assign head_valid = ents[head_ptr].busy;

    always_comb begin
        case ({alloc_we, advance})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            full     <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                ents[i].busy <= 1'b0;
            end
        end else begin
            if (alloc_we) begin
                ents[tail_ptr] <= alloc;
                tail_ptr       <= next_ptr(tail_ptr);
            end

            if (released) begin
                ents[head_ptr].released <= 1'b1;
            end

            if (alu_wb.valid) begin
                if (is_branch(ents[alu_wb.tag].op)) begin
                    if (alu_wb.taken) begin
                        ents[alu_wb.tag].state          <= st_done;
                        ents[alu_wb.tag].payload.target <= alu_wb.value;
                    end else begin
                        ents[alu_wb.tag].state <= st_not_taken;
                    end
                end else begin
                    ents[alu_wb.tag].state          <= st_done;
                    ents[alu_wb.tag].payload.result <= alu_wb.value; // result or jump target.
                end
            end

            if (addr_wb.valid) begin
                ents[addr_wb.tag].state <= st_mem_wait;
            end

            // last, so it wins over a release on the same edge.
            if (mem_wb.valid) begin
                ents[mem_wb.tag].state          <= st_done;
                ents[mem_wb.tag].payload.result <= mem_wb.value;
            end

            if (advance) begin
                ents[head_ptr].busy <= 1'b0;
                head_ptr            <= next_ptr(head_ptr);
            end

            count <= count_next;
            full  <= (count_next == max_count);
        end
    end

    a_alu_wb_busy: assert property (@(posedge clk) disable iff (!rst)
        alu_wb.valid |-> ents[alu_wb.tag].busy);

    a_mem_wb_busy: assert property (@(posedge clk) disable iff (!rst)
        (addr_wb.valid |-> ents[addr_wb.tag].busy) and
        (mem_wb.valid |-> ents[mem_wb.tag].busy));

    // an accept never lands on a live slot, so the count stays within depth.
    a_alloc_free: assert property (@(posedge clk) disable iff (!rst)
        alloc_we |-> !ents[tail_ptr].busy);

endmodule

// ==== design/rob_dispatch.sv ====
`timescale 1ns/1ps

module rob_dispatch (
    input  logic               clk,
    input  logic               rst,
    input  rob_pkg::dispatch_t disp,
    input  logic               disp_valid,
    output logic               disp_ready,
    output logic               alloc_we,
    output rob_pkg::entry_t    alloc,
    input  rob_pkg::tag_t      alloc_tag,
    input  logic               full,
    output rob_pkg::issue_t    issue,
    output logic               issue_valid
);
    import rob_pkg::*;

    logic   no_issue;
    issue_t issue_next;

    assign disp_ready = !full;
    assign alloc_we   = disp_valid && !full;

    // lui and auipc are finished here and never reach a station.
    assign no_issue = (disp.op == op_lui) || (disp.op == op_auipc);

    always_comb begin
        alloc          = '0;
        alloc.op       = disp.op;
        alloc.rd       = disp.rd;
        alloc.pc       = disp.pc;
        alloc.busy     = 1'b1;
        alloc.released = 1'b0;
        alloc.state    = st_exec;
        if (disp.op == op_lui) begin
            alloc.state          = st_done;
            alloc.payload.result = disp.imm;
        end else if (disp.op == op_auipc) begin
            alloc.state          = st_done;
            alloc.payload.result = disp.pc + disp.imm;
        end
    end

    always_comb begin
        issue_next      = '0;
        issue_next.op   = disp.op;
        issue_next.tag  = alloc_tag;
        issue_next.imm  = disp.imm;
        issue_next.src1 = disp.src1;
        if (disp.has_imm && !is_store(disp.op)) begin
            issue_next.src2.value   = disp.imm; // immediate stands in for rs2.
            issue_next.src2.tag     = '0;
            issue_next.src2.pending = 1'b0;
        end else begin
            issue_next.src2 = disp.src2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= alloc_we && !no_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            issue <= issue_next;
        end
    end

    // the decoder holds a request steady until it is taken.
    a_disp_hold: assert property (@(posedge clk) disable iff (!rst)
        (disp_valid && !disp_ready) |=> (disp_valid && $stable(disp)));

endmodule

// ==== design/rob_pkg.sv ====
`include "rob_settings.svh"

package rob_pkg;

    typedef enum logic [4:0] {
        op_add   = 5'b00000,
        op_and   = 5'b00001,
        op_or    = 5'b00010,
        op_sll   = 5'b00011,
        op_srl   = 5'b00100,
        op_slt   = 5'b00101,
        op_sltu  = 5'b00110,
        op_sra   = 5'b00111,
        op_sub   = 5'b01000,
        op_xor   = 5'b01001,
        op_beq   = 5'b01010,
        op_bge   = 5'b01011,
        op_bne   = 5'b01100,
        op_bgeu  = 5'b01101,
        op_lui   = 5'b01110,
        op_auipc = 5'b01111,
        op_jal   = 5'b10000,
        op_jalr  = 5'b10001,
        op_lb    = 5'b10010,
        op_lh    = 5'b10011,
        op_lw    = 5'b10100,
        op_lbu   = 5'b10101,
        op_lhu   = 5'b10110,
        op_sb    = 5'b10111,
        op_sh    = 5'b11000,
        op_sw    = 5'b11001,
        op_blt   = 5'b11010,
        op_bltu  = 5'b11011,
        op_none  = 5'b11111
    } op_e;

    typedef logic [`ROB_TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        st_exec      = 2'b00, // waiting on a unit.
        st_mem_wait  = 2'b01, // address known, needs release.
        st_not_taken = 2'b10,
        st_done      = 2'b11
    } state_e;

    // branches and jumps read the word as a target, all else as a result.
    typedef union packed {
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] target;
    } payload_u;

    typedef struct packed {
        logic [`XLEN-1:0] value;
        tag_t             tag;     // producer when pending.
        logic             pending;
    } operand_t;

    typedef struct packed {
        op_e              op;
        logic [4:0]       rd;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic             has_imm;
        operand_t         src1;
        operand_t         src2;
    } dispatch_t;

    typedef struct packed {
        op_e              op;
        tag_t             tag;
        logic [`XLEN-1:0] imm;
        operand_t         src1;
        operand_t         src2;
    } issue_t;

    typedef struct packed {
        op_e              op;
        logic [4:0]       rd;
        logic [`XLEN-1:0] pc;
        state_e           state;
        logic             busy;
        logic             released; // memory access already let go.
        payload_u         payload;
    } entry_t;

    typedef struct packed {
        logic             valid;
        tag_t             tag;
        logic [`XLEN-1:0] value;
        logic             taken; // branches only.
    } wb_t;

    typedef struct packed {
        logic             commit_valid;
        logic [4:0]       commit_rd;
        logic [`XLEN-1:0] commit_value;
        tag_t             commit_tag;
        logic             mem_release_valid;
        tag_t             mem_release_tag;
        logic             redirect_valid;
        logic [`XLEN-1:0] redirect_pc;
    } retire_t;

    function automatic logic is_branch(op_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

    function automatic logic is_jump(op_e op);
        return op inside {op_jal, op_jalr};
    endfunction

    function automatic logic is_store(op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

// ==== design/rob_retire.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_retire (
    input  logic             clk,
    input  logic             rst,
    input  rob_pkg::entry_t  head,
    input  rob_pkg::tag_t    head_tag,
    input  logic             head_valid,
    output logic             advance,
    output logic             released,
    output rob_pkg::retire_t ret
);
    import rob_pkg::*;

    logic             can_commit;
    logic             can_release;
    logic             head_branch;
    logic             head_jump;
    logic [`XLEN-1:0] link_pc;

    assign head_branch = is_branch(head.op);
    assign head_jump   = is_jump(head.op);
    assign link_pc     = head.pc + `XLEN'(4);

    assign can_commit = head_valid &&
        ((head.state == st_done) || (head.state == st_not_taken));
    assign can_release = head_valid && (head.state == st_mem_wait) && !head.released;

    assign advance  = can_commit;
    assign released = can_release;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ret.commit_valid      <= 1'b0;
            ret.mem_release_valid <= 1'b0;
            ret.redirect_valid    <= 1'b0;
        end else begin
            ret.commit_valid      <= can_commit && (head.rd != 5'd0); // x0 still retires.
            ret.mem_release_valid <= can_release;
            ret.redirect_valid    <= can_commit && (head_branch || head_jump);
        end
    end

    always_ff @(posedge clk) begin
        ret.commit_rd       <= head.rd;
        ret.commit_tag      <= head_tag;
        ret.mem_release_tag <= head_tag;
        if (head_jump) begin
            ret.commit_value <= link_pc;
        end else begin
            ret.commit_value <= head.payload.result;
        end
        if (head.state == st_not_taken) begin
            ret.redirect_pc <= link_pc; // fall through.
        end else begin
            ret.redirect_pc <= head.payload.target;
        end
    end

    // a load or store is let go to memory before it commits.
    a_commit_after_release: assert property (@(posedge clk) disable iff (!rst)
        (can_commit && (head.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu,
                                        op_sb, op_sh, op_sw})) |-> head.released);

endmodule

// ==== design/rob_settings.svh ====
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// data word width.
`define XLEN 32

// reorder buffer entries.
`define ROB_DEPTH 8

// log2 of the depth.
`define ROB_TAG_W 3

`endif

// ==== design/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top (
    input  logic               clk,
    input  logic               rst,
    input  rob_pkg::dispatch_t disp,
    input  logic               disp_valid,
    output logic               disp_ready,
    output rob_pkg::issue_t    issue,
    output logic               issue_valid,
    input  rob_pkg::wb_t       alu_wb,
    input  rob_pkg::wb_t       addr_wb,
    input  rob_pkg::wb_t       mem_wb,
    output rob_pkg::retire_t   ret
);
    import rob_pkg::*;

    logic   alloc_we;
    entry_t alloc;
    tag_t   alloc_tag;
    logic   full;
    entry_t head;
    tag_t   head_tag;
    logic   head_valid;
    logic   advance;
    logic   released;

    rob_dispatch u_dispatch (
        .clk(clk), .rst(rst),
        .disp(disp), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .alloc_we(alloc_we), .alloc(alloc), .alloc_tag(alloc_tag), .full(full),
        .issue(issue), .issue_valid(issue_valid)
    );

    rob_core #(.depth(`ROB_DEPTH)) u_core (
        .clk(clk), .rst(rst),
        .alloc_we(alloc_we), .alloc(alloc), .alloc_tag(alloc_tag), .full(full),
        .alu_wb(alu_wb), .addr_wb(addr_wb), .mem_wb(mem_wb),
        .head(head), .head_tag(head_tag), .head_valid(head_valid),
        .advance(advance), .released(released)
    );

    rob_retire u_retire (
        .clk(clk), .rst(rst),
        .head(head), .head_tag(head_tag), .head_valid(head_valid),
        .advance(advance), .released(released), .ret(ret)
    );

endmodule

// ==== dv/rob_checker.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_checker #(
    parameter int n_rows = 24
) (
    input  logic               clk,
    input  logic               rst,
    input  rob_pkg::dispatch_t disp,
    input  logic               disp_valid,
    input  logic               disp_ready,
    input  rob_pkg::issue_t    issue,
    input  logic               issue_valid,
    input  rob_pkg::retire_t   ret,
    input  logic               hold,
    input  logic [`XLEN-1:0]   exp_value [n_rows],
    input  logic               exp_taken [n_rows],
    output int                 errors,
    output int                 retired
);
    import rob_pkg::*;

    dispatch_t rows [n_rows];
    int        rel_cnt [n_rows];
    int        issue_q [$];
    int        acc_cnt;
    int        ret_idx;

    function automatic logic is_mem_op(op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
    endfunction

    // rows that leave no trace on ret when they retire.
    function automatic logic silent_row(int i);
        return (rows[i].rd == 5'd0) && !is_branch(rows[i].op) && !is_jump(rows[i].op);
    endfunction

    function automatic logic [`XLEN-1:0] expected_commit(int i);
        case (rows[i].op)
            op_lui:         return rows[i].imm;
            op_auipc:       return rows[i].pc + rows[i].imm;
            op_jal, op_jalr: return rows[i].pc + 32'd4;
            default:        return exp_value[i];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] got, inout bit ok);
        if (exp !== got) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, got);
            errors++;
            ok = 0;
        end
    endtask

    function automatic void retire_row(input int i, input bit ok_in);
        bit ok;
        ok = ok_in;
        if (is_mem_op(rows[i].op) && rel_cnt[i] != 1) begin
            $display("row %0d retired after %0d memory releases instead of one", i, rel_cnt[i]);
            errors++;
            ok = 0;
        end
        $display("row %2d %-9s tag %0d %s", i, rows[i].op.name(), i % `ROB_DEPTH,
                 ok ? "pass" : "fail");
        retired++;
    endfunction

    // walk past silent rows up to the row that this retire event belongs to.
    function automatic bit align(tag_t t, bit by_tag);
        while (ret_idx < acc_cnt && silent_row(ret_idx) &&
               !(by_tag && tag_t'(ret_idx % `ROB_DEPTH) == t)) begin
            retire_row(ret_idx, 1'b1);
            ret_idx++;
        end
        if (ret_idx >= acc_cnt || (by_tag && tag_t'(ret_idx % `ROB_DEPTH) != t)) begin
            $display("retire event for tag %0d arrived out of program order", t);
            errors++;
            return 0;
        end
        return 1;
    endfunction

    always @(posedge clk) begin
        int               k;
        bit               ok;
        logic [`XLEN-1:0] exp_pc;
        if (!rst) begin
            errors  = 0;
            retired = 0;
            acc_cnt = 0;
            ret_idx = 0;
        end else begin
            // the buffer is full from the edge after the eighth accept.
            if (hold && acc_cnt >= `ROB_DEPTH && disp_ready) begin
                $display("[FAIL] %0t disp_ready expected 0 actual 1", $time);
                errors++;
            end

            if (issue_valid) begin
                if (issue_q.size() == 0) begin
                    $display("issue record at %0t has no matching dispatch", $time);
                    errors++;
                end else begin
                    ok = 1;
                    k  = issue_q.pop_front();
                    check_value("issue.tag", k % `ROB_DEPTH, issue.tag, ok);
                    check_value("issue.op", rows[k].op, issue.op, ok);
                    check_value("issue.imm", rows[k].imm, issue.imm, ok);
                    check_value("issue.src1.value", rows[k].src1.value, issue.src1.value, ok);
                    check_value("issue.src1.tag", rows[k].src1.tag, issue.src1.tag, ok);
                    check_value("issue.src1.pending", rows[k].src1.pending,
                                issue.src1.pending, ok);
                    if (rows[k].has_imm && !is_store(rows[k].op)) begin
                        check_value("issue.src2.value", rows[k].imm, issue.src2.value, ok);
                        check_value("issue.src2.pending", 0, issue.src2.pending, ok);
                    end else begin
                        check_value("issue.src2.value", rows[k].src2.value,
                                    issue.src2.value, ok);
                        check_value("issue.src2.tag", rows[k].src2.tag, issue.src2.tag, ok);
                        check_value("issue.src2.pending", rows[k].src2.pending,
                                    issue.src2.pending, ok);
                    end
                end
            end

            if (disp_valid && disp_ready) begin
                if (hold && acc_cnt >= `ROB_DEPTH) begin
                    $display("an instruction was accepted while the buffer was full");
                    errors++;
                end
                if (acc_cnt < n_rows) begin
                    rows[acc_cnt]    = disp;
                    rel_cnt[acc_cnt] = 0;
                    if (disp.op != op_lui && disp.op != op_auipc) begin
                        issue_q.push_back(acc_cnt);
                    end
                end
                acc_cnt++;
            end

            if (ret.mem_release_valid && align(ret.mem_release_tag, 1'b1)) begin
                if (!is_mem_op(rows[ret_idx].op)) begin
                    $display("memory release for row %0d, which is not a load or store",
                             ret_idx);
                    errors++;
                end
                rel_cnt[ret_idx]++;
            end

            if ((ret.commit_valid || ret.redirect_valid) &&
                align(ret.commit_tag, ret.commit_valid)) begin
                ok = 1;
                k  = ret_idx;
                check_value("ret.commit_valid", rows[k].rd != 5'd0, ret.commit_valid, ok);
                if (ret.commit_valid) begin
                    check_value("ret.commit_rd", rows[k].rd, ret.commit_rd, ok);
                    check_value("ret.commit_value", expected_commit(k), ret.commit_value, ok);
                end
                if (is_branch(rows[k].op) || is_jump(rows[k].op)) begin
                    exp_pc = (is_jump(rows[k].op) || exp_taken[k]) ? exp_value[k]
                                                                    : rows[k].pc + 32'd4;
                    check_value("ret.redirect_valid", 1, ret.redirect_valid, ok);
                    check_value("ret.redirect_pc", exp_pc, ret.redirect_pc, ok);
                end else begin
                    check_value("ret.redirect_valid", 0, ret.redirect_valid, ok);
                end
                retire_row(k, ok);
                ret_idx++;
            end
        end
    end

endmodule

// ==== dv/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int n_rows    = 24;
    localparam int wd_cycles = n_rows * 40;

    typedef struct packed {
        op_e              op;
        logic [4:0]       rd;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic             has_imm;
        logic [`XLEN-1:0] s1_val;
        logic [`XLEN-1:0] s2_val;
        logic [`XLEN-1:0] value; // result, target or loaded word.
        logic             taken;
    } row_t;

    logic             clk;
    logic             rst;
    dispatch_t        disp;
    logic             disp_valid;
    logic             disp_ready;
    issue_t           issue;
    logic             issue_valid;
    wb_t              alu_wb;
    wb_t              addr_wb;
    wb_t              mem_wb;
    retire_t          ret;
    logic             hold;
    row_t             tbl [n_rows];
    logic [`XLEN-1:0] exp_value [n_rows];
    logic             exp_taken [n_rows];
    int               errors;
    int               retired;
    int               accepted;
    int               tag_row [`ROB_DEPTH];
    int               alu_tag_q [$];
    int               alu_due_q [$];
    int               addr_tag_q [$];
    int               addr_due_q [$];
    int               cycle_n;
    logic [31:0]      rng_state;

    rob_top dut (
        .clk(clk), .rst(rst),
        .disp(disp), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .issue(issue), .issue_valid(issue_valid),
        .alu_wb(alu_wb), .addr_wb(addr_wb), .mem_wb(mem_wb), .ret(ret)
    );

    rob_checker #(.n_rows(n_rows)) u_checker (
        .clk(clk), .rst(rst),
        .disp(disp), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .issue(issue), .issue_valid(issue_valid), .ret(ret), .hold(hold),
        .exp_value(exp_value), .exp_taken(exp_taken),
        .errors(errors), .retired(retired)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_mem_op(op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
    endfunction

    function automatic int find_due(int due[$], int now);
        foreach (due[j]) begin
            if (due[j] <= now) return j;
        end
        return -1;
    endfunction

    function automatic wb_t make_wb(int t);
        wb_t w;
        w.valid = 1'b1;
        w.tag   = tag_t'(t);
        w.value = tbl[tag_row[t]].value;
        w.taken = tbl[tag_row[t]].taken;
        return w;
    endfunction

    function automatic dispatch_t make_disp(int i);
        dispatch_t d;
        d              = '0;
        d.op           = tbl[i].op;
        d.rd           = tbl[i].rd;
        d.pc           = tbl[i].pc;
        d.imm          = tbl[i].imm;
        d.has_imm      = tbl[i].has_imm;
        d.src1.value   = tbl[i].s1_val;
        d.src1.tag     = tag_t'((i + 7) % `ROB_DEPTH);
        d.src1.pending = (i % 3 == 0);
        d.src2.value   = tbl[i].s2_val;
        d.src2.tag     = tag_t'((i + 6) % `ROB_DEPTH);
        d.src2.pending = (i % 4 == 1);
        return d;
    endfunction

    task automatic set_row(input int i, input op_e op, input logic [4:0] rd,
                           input logic [31:0] imm, input logic has_imm,
                           input logic [31:0] value, input logic taken);
        tbl[i]         = '0;
        tbl[i].op      = op;
        tbl[i].rd      = rd;
        tbl[i].pc      = 32'h100 + 4 * i;
        tbl[i].imm     = imm;
        tbl[i].has_imm = has_imm;
        tbl[i].s1_val  = 3 * i + 1;
        tbl[i].s2_val  = 5 * i + 2;
        tbl[i].value   = value;
        tbl[i].taken   = taken;
        exp_value[i]   = value;
        exp_taken[i]   = taken;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        disp       = '0;
        disp_valid = 1'b0;
        alu_wb     = '0;
        addr_wb    = '0;
        mem_wb     = '0;
        hold       = 1'b1;
        accepted   = 0;
        cycle_n    = 0;
        rng_state  = 32'hc227;
        // the first eight rows all go to a unit, so none retires during hold.
        set_row(0,  op_add,   5'd1,  32'h0,        1'b0, 32'd30,       1'b0);
        set_row(1,  op_lw,    5'd2,  32'h8,        1'b1, 32'hdead,     1'b0);
        set_row(2,  op_beq,   5'd0,  32'h10,       1'b0, 32'h118,      1'b1);
        set_row(3,  op_sub,   5'd3,  32'h0,        1'b0, 32'd5,        1'b0);
        set_row(4,  op_jal,   5'd1,  32'h40,       1'b1, 32'h150,      1'b0);
        set_row(5,  op_sw,    5'd0,  32'h4,        1'b1, 32'h0,        1'b0);
        set_row(6,  op_add,   5'd4,  32'h7,        1'b1, 32'd17,       1'b0);
        set_row(7,  op_bne,   5'd0,  32'h20,       1'b0, 32'h200,      1'b0);
        set_row(8,  op_lui,   5'd5,  32'h12345000, 1'b1, 32'h0,        1'b0);
        set_row(9,  op_auipc, 5'd6,  32'h1000,     1'b1, 32'h0,        1'b0);
        set_row(10, op_xor,   5'd7,  32'h0,        1'b0, 32'hff,       1'b0);
        set_row(11, op_lbu,   5'd8,  32'h1,        1'b1, 32'h7f,       1'b0);
        set_row(12, op_add,   5'd0,  32'h0,        1'b0, 32'd9,        1'b0);
        set_row(13, op_jalr,  5'd9,  32'h4,        1'b1, 32'h300,      1'b0);
        set_row(14, op_blt,   5'd0,  32'h8,        1'b0, 32'h100,      1'b1);
        set_row(15, op_sh,    5'd0,  32'h2,        1'b1, 32'h0,        1'b0);
        set_row(16, op_or,    5'd10, 32'h0,        1'b0, 32'hf0,       1'b0);
        set_row(17, op_sll,   5'd11, 32'h3,        1'b1, 32'h80,       1'b0);
        set_row(18, op_bgeu,  5'd0,  32'h30,       1'b0, 32'h400,      1'b0);
        set_row(19, op_lh,    5'd12, 32'h6,        1'b1, 32'hffff8000, 1'b0);
        set_row(20, op_sltu,  5'd13, 32'h0,        1'b0, 32'd1,        1'b0);
        set_row(21, op_lui,   5'd14, 32'habcde000, 1'b1, 32'h0,        1'b0);
        set_row(22, op_sra,   5'd15, 32'h2,        1'b1, 32'hfffffff0, 1'b0);
        set_row(23, op_add,   5'd16, 32'h0,        1'b0, 32'h1234,     1'b0);
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            disp       <= make_disp(i);
            disp_valid <= 1'b1;
            @(posedge clk);
            while (!disp_ready) @(posedge clk);
            tag_row[i % `ROB_DEPTH] = i; // tags are handed out in order.
            accepted = i + 1;
        end
        disp_valid <= 1'b0;
    end

    // writebacks stay withheld until the buffer has been full for a while.
    initial begin
        wait (accepted == `ROB_DEPTH);
        repeat (6) @(posedge clk);
        hold <= 1'b0;
    end

    // alu, address and memory unit models.
    always @(posedge clk) begin
        int j;
        cycle_n = cycle_n + 1;
        if (rst && issue_valid) begin
            rng_state = xorshift32(rng_state);
            if (is_mem_op(issue.op)) begin
                addr_tag_q.push_back(issue.tag);
                addr_due_q.push_back(cycle_n + 1 + rng_state % 6);
            end else begin
                alu_tag_q.push_back(issue.tag);
                alu_due_q.push_back(cycle_n + 1 + rng_state % 6);
            end
        end
        alu_wb  <= '0;
        addr_wb <= '0;
        mem_wb  <= '0;
        if (!hold) begin
            j = find_due(alu_due_q, cycle_n);
            if (j >= 0) begin
                alu_wb <= make_wb(alu_tag_q[j]);
                alu_tag_q.delete(j);
                alu_due_q.delete(j);
            end
            j = find_due(addr_due_q, cycle_n);
            if (j >= 0) begin
                addr_wb <= make_wb(addr_tag_q[j]);
                addr_tag_q.delete(j);
                addr_due_q.delete(j);
            end
        end
        if (rst && ret.mem_release_valid) begin
            mem_wb <= make_wb(ret.mem_release_tag);
        end
    end

    initial begin
        wait (rst && retired == n_rows);
        repeat (4) @(posedge clk);
        $display("rows %0d retired %0d errors %0d", n_rows, retired, errors);
        if (errors == 0 && retired == n_rows) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout after %0d cycles with only %0d of %0d rows retired",
                 wd_cycles, retired, n_rows);
        $display("rows %0d retired %0d errors %0d", n_rows, retired, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_core.sv
design/rob_retire.sv
design/rob_top.sv
dv/rob_checker.sv
dv/rob_tb.sv
